// File: design/sfm_pkg.sv
package sfm_pkg;

    // #####################
    // datapath widths
    // #####################
    localparam int unsigned SAMPLE_W    = 16;
    localparam int unsigned SUM_W       = 24;
    localparam int unsigned MAX_SAMPLES = 256;  // 256 samples of 16 bits fit in SUM_W

    localparam int unsigned MANT_W    = 16;     // Q1.15 mantissa and reciprocal
    localparam int unsigned SHIFT_W   = 5;
    localparam int unsigned SEED_BITS = 4;

    // #####################
    // pipeline depths
    // #####################
    localparam int unsigned ADD_STAGES = 3;
    localparam int unsigned FIFO_DEPTH = 8;
    localparam int unsigned CNT_W      = $clog2(ADD_STAGES + 1);

    localparam int unsigned N_INV_ITERS = 2;
    localparam int unsigned INV_LATENCY = 2 + 2 * N_INV_ITERS;  // normalize, seed, then two per step
    localparam int unsigned INV_STEP_W  = $clog2(INV_LATENCY);

    typedef enum logic [2:0] {
        IDLE,
        COMPUTING,
        FINISHING,
        REDUCTION,
        INVERSION,
        FINISHED
    } acc_state_t;

endpackage

// File: design/sfm_fifo.sv
`timescale 1ns/1ns

module sfm_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 8
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] data_o,
    output logic             full_o,
    output logic             empty_o
);

    localparam int unsigned ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W  = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]  mem_q [DEPTH];
    logic [ADDR_W-1:0] rd_ptr_q;
    logic [ADDR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0]  count_q;
    logic              do_push;
    logic              do_pop;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;
    assign data_o  = mem_q[rd_ptr_q];  // head is visible the cycle after it was written

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
        !(push_i && full_o)) else $error("push into a full FIFO");

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni || flush_i)
        !(pop_i && empty_o)) else $error("pop from an empty FIFO");

endmodule

// File: design/sfm_pipe_adder.sv
`timescale 1ns/1ns

module sfm_pipe_adder import sfm_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    input  logic             valid_i,
    input  logic [SUM_W-1:0] a_i,
    input  logic [SUM_W-1:0] b_i,
    output logic             valid_o,
    output logic [SUM_W-1:0] sum_o
);

    logic [SUM_W-1:0]      sum_q [ADD_STAGES];
    logic [ADD_STAGES-1:0] valid_q;

    // the valid bits form a shift register, flush drops every operation in flight
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[ADD_STAGES-2:0], valid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        sum_q[0] <= a_i + b_i;  // add first, the remaining stages only carry the result
        for (int i = 1; i < ADD_STAGES; i++) begin
            sum_q[i] <= sum_q[i-1];
        end
    end

    assign valid_o = valid_q[ADD_STAGES-1];
    assign sum_o   = sum_q[ADD_STAGES-1];

endmodule

// File: design/sfm_acc_ctrl.sv
`timescale 1ns/1ns

module sfm_acc_ctrl import sfm_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       clear_i,
    input  logic       add_fire_i,
    input  logic       acc_finished_i,
    input  logic       acc_only_i,
    input  logic       fifo_empty_i,
    input  logic       fifo_full_i,
    input  logic       add_out_valid_i,
    input  logic       inv_valid_i,
    output acc_state_t state_o,
    output logic       fifo_pop_o,
    output logic       fifo_push_o,
    output logic       push_result_o,
    output logic       adder_valid_o,
    output logic       use_fifo_o,
    output logic       use_result_o,
    output logic       total_o,
    output logic       inv_start_o,
    output logic       ready_o
);

    acc_state_t       state_q;
    acc_state_t       state_d;
    logic [CNT_W-1:0] in_flight_q;
    logic             cnt_inc;
    logic             cnt_dec;
    logic             toggle_q;
    logic             toggle_en;
    logic             acc_only_q;
    logic             inv_start_q;
    logic             accumulating;

    // samples are refused only while the partial sums are being reduced or inverted
    assign accumulating = (state_q != REDUCTION) && (state_q != INVERSION);
    assign ready_o      = ~fifo_full_i & accumulating;
    assign fifo_push_o  = add_fire_i | push_result_o;
    assign state_o      = state_q;
    assign inv_start_o  = inv_start_q;

    // ####################
    // operand selection and next state
    // ####################
    always_comb begin
        state_d       = state_q;
        fifo_pop_o    = 1'b0;
        push_result_o = 1'b0;
        adder_valid_o = 1'b0;
        use_fifo_o    = 1'b0;
        use_result_o  = 1'b0;
        total_o       = 1'b0;
        cnt_inc       = 1'b0;
        cnt_dec       = 1'b0;
        toggle_en     = 1'b0;

        if (accumulating) begin
            if (add_out_valid_i) begin
                use_result_o  = 1'b1;            // a circulating sum always goes back in
                adder_valid_o = 1'b1;
                fifo_pop_o    = ~fifo_empty_i;
                use_fifo_o    = ~fifo_empty_i;
            end else if (!fifo_empty_i && (in_flight_q < CNT_W'(ADD_STAGES))) begin
                fifo_pop_o    = 1'b1;            // open a new partial sum in the free slot
                use_fifo_o    = 1'b1;
                adder_valid_o = 1'b1;
                cnt_inc       = 1'b1;
            end
        end

        case (state_q)
            IDLE, FINISHED: begin
                if (add_fire_i) begin
                    state_d = COMPUTING;
                end
            end
            COMPUTING: begin
                if (acc_finished_i) begin
                    state_d = FINISHING;
                end
            end
            FINISHING: begin
                if (fifo_empty_i) begin
                    state_d = REDUCTION;
                end
            end
            REDUCTION: begin
                if (add_out_valid_i) begin
                    if (in_flight_q == CNT_W'(1)) begin
                        total_o = 1'b1;          // last sum standing
                        cnt_dec = 1'b1;
                        state_d = acc_only_q ? IDLE : INVERSION;
                    end else if (!toggle_q) begin
                        // park this sum until its partner comes out
                        push_result_o = 1'b1;
                        toggle_en     = 1'b1;
                    end else begin
                        fifo_pop_o    = 1'b1;
                        use_fifo_o    = 1'b1;
                        use_result_o  = 1'b1;
                        adder_valid_o = 1'b1;
                        cnt_dec       = 1'b1;
                        toggle_en     = 1'b1;
                    end
                end
            end
            INVERSION: begin
                if (inv_valid_i) begin
                    state_d = FINISHED;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= IDLE;
            in_flight_q <= '0;
            toggle_q    <= 1'b0;
            acc_only_q  <= 1'b0;
            inv_start_q <= 1'b0;
        end else if (clear_i) begin
            state_q     <= IDLE;
            in_flight_q <= '0;
            toggle_q    <= 1'b0;
            acc_only_q  <= 1'b0;
            inv_start_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            toggle_q    <= toggle_q ^ toggle_en;
            inv_start_q <= total_o & ~acc_only_q;  // lines up with acc_done in the top
            if (acc_finished_i) begin
                acc_only_q <= acc_only_i;
            end
            if (cnt_dec) begin
                in_flight_q <= in_flight_q - 1'b1;
            end else if (cnt_inc) begin
                in_flight_q <= in_flight_q + 1'b1;
            end
        end
    end

    // with every adder slot counted a circulating sum leaves the adder each cycle
    a_in_flight_bound: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        (accumulating && in_flight_q == CNT_W'(ADD_STAGES)) |-> add_out_valid_i)
        else $error("more partial sums counted than the adder holds");

endmodule

// File: design/sfm_den_inverter.sv
`timescale 1ns/1ns

module sfm_den_inverter import sfm_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               clear_i,
    input  logic               start_i,
    input  logic [SUM_W-1:0]   den_i,
    output logic               valid_o,
    output logic [MANT_W-1:0]  recip_o,
    output logic [SHIFT_W-1:0] shift_o
);

    localparam int unsigned N_SEEDS = 2 ** SEED_BITS;

    logic [SHIFT_W-1:0]    lead;
    logic [SUM_W-1:0]      norm_full;
    logic [MANT_W-1:0]     norm_m;
    logic [MANT_W-1:0]     seed_rom [N_SEEDS];
    logic [MANT_W-1:0]     m_q;
    logic [MANT_W-1:0]     y_q;
    logic [MANT_W-1:0]     e_q;
    logic [SHIFT_W-1:0]    p_q;
    logic                  zero_q;
    logic [INV_STEP_W-1:0] step_q;
    logic                  valid_q;
    logic                  seed_step;
    logic                  e_step;
    logic                  y_step;
    logic [MANT_W-1:0]     mul_a;
    logic [MANT_W-1:0]     mul_b;
    logic [2*MANT_W-1:0]   prod;
    logic [MANT_W-1:0]     prod_q15;
    logic [MANT_W:0]       e_full;

    // reciprocal of the interval midpoint, truncated to Q1.15
    function automatic logic [MANT_W-1:0] seed_value(int unsigned idx);
        int unsigned num;
        int unsigned den;
        num = 2 ** (MANT_W + SEED_BITS);
        den = 2 ** (SEED_BITS + 1) + 2 * idx + 1;
        return MANT_W'(num / den);
    endfunction

    for (genvar g = 0; g < N_SEEDS; g++) begin : gen_seed
        assign seed_rom[g] = seed_value(g);
    end

    // ####################
    // leading one and normalization
    // ####################
    always_comb begin
        lead = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (den_i[i]) begin
                lead = SHIFT_W'(i);
            end
        end
        if (lead >= SHIFT_W'(MANT_W - 1)) begin
            norm_full = den_i >> (lead - SHIFT_W'(MANT_W - 1));
        end else begin
            norm_full = den_i << (SHIFT_W'(MANT_W - 1) - lead);
        end
        norm_m = norm_full[MANT_W-1:0];  // leading one now sits at bit 15
    end

    // step 1 loads the seed, even steps form e and odd steps refine y
    assign seed_step = (step_q == INV_STEP_W'(1));
    assign e_step    = (step_q != '0) & ~step_q[0];
    assign y_step    = step_q[0] & ~seed_step;

    // one multiplier shared by both halves of an iteration
    assign mul_a    = e_step ? m_q : y_q;
    assign mul_b    = e_step ? y_q : e_q;
    assign prod     = mul_a * mul_b;
    assign prod_q15 = prod[2*MANT_W-2 -: MANT_W];
    assign e_full   = {1'b1, {MANT_W{1'b0}}} - {1'b0, prod_q15};  // 2.0 minus m*y

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            step_q  <= '0;
            valid_q <= 1'b0;
        end else if (clear_i) begin
            step_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (start_i) begin
                step_q <= INV_STEP_W'(1);
            end else if (step_q == INV_STEP_W'(INV_LATENCY - 1)) begin
                step_q  <= '0;
                valid_q <= 1'b1;
            end else if (step_q != '0) begin
                step_q <= step_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            m_q    <= norm_m;
            p_q    <= lead;
            zero_q <= (den_i == '0);
        end
        if (seed_step) begin
            y_q <= seed_rom[m_q[MANT_W-2 -: SEED_BITS]];
        end else if (y_step) begin
            y_q <= prod_q15;
        end
        if (e_step) begin
            e_q <= e_full[MANT_W-1:0];  // e stays below 2 so the top bit is dropped
        end
    end

    assign valid_o = valid_q;
    assign recip_o = zero_q ? '1 : y_q;
    assign shift_o = p_q;

endmodule

// File: design/sfm_accumulator.sv
`timescale 1ns/1ns

module sfm_accumulator import sfm_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                add_valid_i,
    input  logic [SAMPLE_W-1:0] add_i,
    input  logic                acc_finished_i,
    input  logic                acc_only_i,
    output logic                ready_o,
    output logic                acc_done_o,
    output logic [SUM_W-1:0]    sum_o,
    output logic                valid_o,
    output logic [MANT_W-1:0]   recip_o,
    output logic [SHIFT_W-1:0]  recip_shift_o
);

    acc_state_t         state;
    logic               add_fire;
    logic               fifo_push;
    logic               fifo_pop;
    logic               fifo_full;
    logic               fifo_empty;
    logic [SUM_W-1:0]   fifo_din;
    logic [SUM_W-1:0]   fifo_dout;
    logic               push_result;
    logic               adder_valid;
    logic               use_fifo;
    logic               use_result;
    logic [SUM_W-1:0]   add_a;
    logic [SUM_W-1:0]   add_b;
    logic               add_out_valid;
    logic [SUM_W-1:0]   add_sum;
    logic               total;
    logic               inv_start;
    logic               inv_valid;
    logic [MANT_W-1:0]  inv_recip;
    logic [SHIFT_W-1:0] inv_shift;

    assign add_fire = add_valid_i & ready_o;
    assign fifo_din = push_result ? add_sum : SUM_W'(add_i);  // parked sums share the FIFO
    assign add_a    = use_result ? add_sum : '0;
    assign add_b    = use_fifo ? fifo_dout : '0;
    assign valid_o  = (state == FINISHED);

    sfm_fifo #(
        .WIDTH (SUM_W),
        .DEPTH (FIFO_DEPTH)
    ) addend_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .push_i  (fifo_push),
        .data_i  (fifo_din),
        .pop_i   (fifo_pop),
        .data_o  (fifo_dout),
        .full_o  (fifo_full),
        .empty_o (fifo_empty)
    );

    sfm_pipe_adder adder (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (clear_i),
        .valid_i (adder_valid),
        .a_i     (add_a),
        .b_i     (add_b),
        .valid_o (add_out_valid),
        .sum_o   (add_sum)
    );

    sfm_acc_ctrl ctrl (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .clear_i         (clear_i),
        .add_fire_i      (add_fire),
        .acc_finished_i  (acc_finished_i),
        .acc_only_i      (acc_only_i),
        .fifo_empty_i    (fifo_empty),
        .fifo_full_i     (fifo_full),
        .add_out_valid_i (add_out_valid),
        .inv_valid_i     (inv_valid),
        .state_o         (state),
        .fifo_pop_o      (fifo_pop),
        .fifo_push_o     (fifo_push),
        .push_result_o   (push_result),
        .adder_valid_o   (adder_valid),
        .use_fifo_o      (use_fifo),
        .use_result_o    (use_result),
        .total_o         (total),
        .inv_start_o     (inv_start),
        .ready_o         (ready_o)
    );

    // the inverter reads the registered total, so it starts with acc_done
    sfm_den_inverter inverter (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .clear_i (clear_i),
        .start_i (inv_start),
        .den_i   (sum_o),
        .valid_o (inv_valid),
        .recip_o (inv_recip),
        .shift_o (inv_shift)
    );

    // ####################
    // output registers
    // ####################
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            sum_o      <= '0;
            acc_done_o <= 1'b0;
        end else if (clear_i) begin
            acc_done_o <= 1'b0;
        end else begin
            acc_done_o <= total;
            if (total) begin
                sum_o <= add_sum;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            recip_o       <= '0;
            recip_shift_o <= '0;
        end else if (inv_valid) begin
            recip_o       <= inv_recip;
            recip_shift_o <= inv_shift;  // held while valid_o is high in FINISHED
        end
    end

    a_recip_latency: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        (acc_done_o && (state == INVERSION)) |-> ##(INV_LATENCY + 1) $rose(valid_o))
        else $error("reciprocal did not arrive on time");

    // each parked sum is combined before the next one is parked
    a_reduce_one_parked: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
        ((state == REDUCTION) && push_result) |-> fifo_empty)
        else $error("a second sum was parked before the first was combined");

endmodule

// File: tb/sfm_checker.sv
`timescale 1ns/1ns

module sfm_checker import sfm_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                clear_i,
    input  logic                add_valid_i,
    input  logic [SAMPLE_W-1:0] add_i,
    input  logic                acc_finished_i,
    input  logic                acc_only_i,
    input  logic                ready_i,
    input  logic                acc_done_i,
    input  logic [SUM_W-1:0]    sum_i,
    input  logic                valid_i,
    input  logic [MANT_W-1:0]   recip_i,
    input  logic [SHIFT_W-1:0]  recip_shift_i,
    output int                  checks_o,
    output int                  errors_o
);

    string            test_name = "reset";
    logic [SUM_W-1:0] exp_sum;
    logic [SUM_W-1:0] total;
    logic             pending;
    logic             only_q;
    logic             valid_q;
    logic             recip_due;
    logic             reset_seen;
    int               since_done;

    initial begin
        checks_o   = 0;
        errors_o   = 0;
        reset_seen = 1'b0;
        total      = '0;
    end

    task automatic start_test(input string name);
        test_name = name;
    endtask

    task automatic compare(input string what, input longint expected, input longint actual);
        checks_o++;
        if (expected != actual) begin
            errors_o++;
            $display("** Error [%s] %s: expected %0h, got %0h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        checks_o++;
        errors_o++;
        $display("test %s failed: %s", test_name, what);
    endtask

    // 1/S = recip * 2^-(15+p), so recip times the normalized m should be close to one
    task automatic check_recip(input logic [SUM_W-1:0] s);
        int     p;
        longint m;
        longint one_q30;
        longint diff;
        p       = 0;
        one_q30 = longint'(1) << 30;
        for (int i = 0; i < SUM_W; i++) begin
            if (s[i]) begin
                p = i;
            end
        end
        if (s == '0) begin
            compare("recip_o of zero", {MANT_W{1'b1}}, recip_i);
            compare("recip_shift_o of zero", 0, recip_shift_i);
        end else begin
            m    = (p >= 15) ? longint'(s) >> (p - 15) : longint'(s) << (15 - p);
            diff = longint'(recip_i) * m - one_q30;
            diff = (diff < 0) ? -diff : diff;
            compare("recip_shift_o", p, recip_shift_i);
            checks_o++;
            if (diff > (longint'(1) << 17)) begin  // more than 2^-13 away from one
                errors_o++;
                $display("** Error [%s] recip_o: expected %0h, got %0h",
                         test_name, one_q30 / m, recip_i);
            end
        end
    endtask

    always @(posedge clk_i) begin
        if (!rst_ni) begin
            exp_sum    = '0;
            pending    = 1'b0;
            only_q     = 1'b0;
            valid_q    = 1'b0;
            recip_due  = 1'b0;
            since_done = 0;
        end else begin
            if (!reset_seen) begin
                reset_seen = 1'b1;
                compare("ready_o after reset", 1, ready_i);
                compare("acc_done_o after reset", 0, acc_done_i);
                compare("valid_o after reset", 0, valid_i);
                compare("sum_o after reset", 0, sum_i);
            end
            since_done++;
            if (clear_i) begin
                exp_sum   = '0;  // the cleared batch is thrown away
                pending   = 1'b0;
                recip_due = 1'b0;
            end else begin
                if (acc_done_i) begin
                    if (!pending) begin
                        report_failure("acc_done_o pulsed with no finished batch");
                    end
                    compare("sum_o", exp_sum, sum_i);
                    total      = exp_sum;
                    exp_sum    = '0;
                    pending    = 1'b0;
                    recip_due  = !only_q;
                    since_done = 0;
                end
                if (add_valid_i && ready_i) begin
                    exp_sum = exp_sum + SUM_W'(add_i);
                end
                if (acc_finished_i) begin
                    pending = 1'b1;
                    only_q  = acc_only_i;
                end
            end
            if (valid_i && !valid_q) begin
                if (only_q) begin
                    report_failure("valid_o rose although acc_only was set");
                end else begin
                    recip_due = 1'b0;
                    compare("valid_o latency", INV_LATENCY + 1, since_done);
                    check_recip(total);
                end
            end
            if (recip_due && since_done > INV_LATENCY + 1) begin
                report_failure("valid_o did not rise after acc_done_o");
                recip_due = 1'b0;
            end
            valid_q = valid_i;
        end
    end

endmodule

// File: tb/tb_sfm_accumulator.sv
`timescale 1ns/1ns

module tb_sfm_accumulator import sfm_pkg::*; ();

    localparam int CLK_HALF      = 4;
    localparam int RESET_CYCLES  = 8;
    localparam int SAMPLE_CYCLES = 40;   // watchdog allowance per sample
    localparam int BATCH_CYCLES  = 200;  // and per batch

    typedef enum int {PAT_CONST, PAT_RAMP, PAT_RAND} pattern_t;

    typedef struct {
        string               name;
        int                  count;
        pattern_t            pattern;
        logic [SAMPLE_W-1:0] base;
        bit                  acc_only;
        bit                  clear_mid;
    } row_t;

    logic                clk_i = 1'b0;
    logic                rst_ni;
    logic                clear_i;
    logic                add_valid_i;
    logic [SAMPLE_W-1:0] add_i;
    logic                acc_finished_i;
    logic                acc_only_i;
    logic                ready_o;
    logic                acc_done_o;
    logic [SUM_W-1:0]    sum_o;
    logic                valid_o;
    logic [MANT_W-1:0]   recip_o;
    logic [SHIFT_W-1:0]  recip_shift_o;
    int                  checks;
    int                  errors;
    row_t                rows [$];
    logic [31:0]         rand_state = 32'd3703;

    always #CLK_HALF clk_i = ~clk_i;

    sfm_accumulator dut0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .add_valid_i    (add_valid_i),
        .add_i          (add_i),
        .acc_finished_i (acc_finished_i),
        .acc_only_i     (acc_only_i),
        .ready_o        (ready_o),
        .acc_done_o     (acc_done_o),
        .sum_o          (sum_o),
        .valid_o        (valid_o),
        .recip_o        (recip_o),
        .recip_shift_o  (recip_shift_o)
    );

    sfm_checker chk0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .clear_i        (clear_i),
        .add_valid_i    (add_valid_i),
        .add_i          (add_i),
        .acc_finished_i (acc_finished_i),
        .acc_only_i     (acc_only_i),
        .ready_i        (ready_o),
        .acc_done_i     (acc_done_o),
        .sum_i          (sum_o),
        .valid_i        (valid_o),
        .recip_i        (recip_o),
        .recip_shift_i  (recip_shift_o),
        .checks_o       (checks),
        .errors_o       (errors)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [SAMPLE_W-1:0] sample_value(input int r, input int idx);
        case (rows[r].pattern)
            PAT_RAMP: return rows[r].base + SAMPLE_W'(idx);
            PAT_RAND: begin
                rand_state = xorshift32(rand_state);
                return rand_state[SAMPLE_W-1:0];
            end
            default: return rows[r].base;
        endcase
    endfunction

    task automatic add_row(input string name, input int count, input pattern_t pattern,
                           input logic [SAMPLE_W-1:0] base, input bit acc_only,
                           input bit clear_mid);
        row_t row;
        row.name      = name;
        row.count     = count;
        row.pattern   = pattern;
        row.base      = base;
        row.acc_only  = acc_only;
        row.clear_mid = clear_mid;
        rows.push_back(row);
    endtask

    // ####################
    // stimulus table
    // ####################
    task automatic build_table();
        //       name              count        pattern    base      only  clear
        add_row("one_sample",      1,           PAT_CONST, 16'h1234, 1'b0, 1'b0);
        add_row("max_ramp",        MAX_SAMPLES, PAT_RAMP,  16'h0100, 1'b0, 1'b0);
        add_row("max_full_scale",  MAX_SAMPLES, PAT_CONST, 16'hffff, 1'b0, 1'b0);
        add_row("random_short",    37,          PAT_RAND,  16'h0000, 1'b0, 1'b0);
        add_row("acc_only_random", 24,          PAT_RAND,  16'h0000, 1'b1, 1'b0);
        add_row("clear_midway",    40,          PAT_RAND,  16'h0000, 1'b0, 1'b1);
        add_row("after_clear",     12,          PAT_RAMP,  16'h0007, 1'b0, 1'b0);
        add_row("all_zero",        16,          PAT_CONST, 16'h0000, 1'b0, 1'b0);
        add_row("random_long",     150,         PAT_RAND,  16'h0000, 1'b0, 1'b0);
        add_row("acc_only_one",    1,           PAT_CONST, 16'h0001, 1'b1, 1'b0);
    endtask

    // a sample that meets ready_o low is held until it transfers
    task automatic send_samples(input int r, input int n);
        int  sent;
        bit  holding;
        sent    = 0;
        holding = 1'b0;
        while (sent < n) begin
            @(negedge clk_i);
            rand_state = (rows[r].pattern == PAT_RAND) ? xorshift32(rand_state) : rand_state;
            if (!holding && rows[r].pattern == PAT_RAND && rand_state[1:0] == 2'b00) begin
                add_valid_i = 1'b0;  // idle cycle between random samples
            end else begin
                if (!holding) begin
                    add_i = sample_value(r, sent);
                end
                add_valid_i = 1'b1;
                holding     = !ready_o;  // ready_o only changes on the rising edge
                if (ready_o) begin
                    sent++;
                end
            end
        end
    endtask

    // the next batch starts at acc_done_o so that its first sample meets ready_o low
    // while the reciprocal is computed
    task automatic wait_result(input bit acc_only);
        @(negedge clk_i);
        while (!acc_done_o) begin
            @(negedge clk_i);
        end
        if (acc_only) begin
            repeat (INV_LATENCY + 4) @(negedge clk_i);  // valid_o must stay low here
        end
    endtask

    // the name switches when the samples are in, the previous reciprocal may still be due
    task automatic run_row(input int r);
        if (rows[r].clear_mid) begin
            send_samples(r, rows[r].count / 2);
            @(negedge clk_i);
            chk0.start_test(rows[r].name);
            add_valid_i = 1'b0;
            clear_i     = 1'b1;
            @(negedge clk_i);
            clear_i = 1'b0;
            repeat (4) @(negedge clk_i);
        end else begin
            send_samples(r, rows[r].count);
            @(negedge clk_i);
            chk0.start_test(rows[r].name);
            add_valid_i    = 1'b0;
            acc_finished_i = 1'b1;
            acc_only_i     = rows[r].acc_only;
            @(negedge clk_i);
            acc_finished_i = 1'b0;
            acc_only_i     = 1'b0;
            wait_result(rows[r].acc_only);
        end
    endtask

    initial begin
        rst_ni         = 1'b0;
        clear_i        = 1'b0;
        add_valid_i    = 1'b0;
        add_i          = '0;
        acc_finished_i = 1'b0;
        acc_only_i     = 1'b0;
        build_table();
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_ni = 1'b1;
        foreach (rows[r]) begin
            run_row(r);
        end
        repeat (4) @(negedge clk_i);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (rst_ni === 1'b1);
        limit = 0;
        foreach (rows[r]) begin
            limit += SAMPLE_CYCLES * rows[r].count + BATCH_CYCLES;
        end
        repeat (limit) @(posedge clk_i);
        $display("timeout: the DUT gave no result within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

endmodule

// File: all.f
design/sfm_pkg.sv
design/sfm_fifo.sv
design/sfm_pipe_adder.sv
design/sfm_acc_ctrl.sv
design/sfm_den_inverter.sv
design/sfm_accumulator.sv
tb/sfm_checker.sv
tb/tb_sfm_accumulator.sv

// File: run.sh
#!/bin/sh
# build and run the softmax denominator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_sfm_accumulator \
    -f all.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
